/* design/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    // Base RV32I major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // Load funct3 values
    // Bit 2 set means zero extension
    typedef enum logic [2:0] {
        LD_B  = 3'b000,
        LD_H  = 3'b001,
        LD_W  = 3'b010,
        LD_BU = 3'b100,
        LD_HU = 3'b101
    } load_width_e;

    // Instruction field positions
    localparam int OPCODE_LSB = 0;
    localparam int OPCODE_MSB = 6;
    localparam int RD_LSB     = 7;
    localparam int RD_MSB     = 11;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_MSB = 14;

endpackage

/* design/wb_cfg_pkg.sv */
package wb_cfg_pkg;

    import rv_isa_pkg::*;

    // Byte offset of a load address inside its word
    typedef logic [1:0] byte_off_t;

    // Source of the register file write data
    typedef enum logic [1:0] {
        WB_NONE = 2'b00,
        WB_LINK = 2'b01,
        WB_ALU  = 2'b10,
        WB_LOAD = 2'b11
    } wb_sel_e;

    // Link address is the next sequential pc
    localparam word_t PC_STEP = 32'd4;

    // Value of the registered pc out of reset
    localparam word_t RESET_PC = 32'h8000_0000;

endpackage

/* design/load_align.sv */
module load_align
    import rv_isa_pkg::*;
    import wb_cfg_pkg::*;
(
    input  load_width_e funct3_i,
    input  byte_off_t   addr_lo_i,
    input  word_t       rdata_i,
    output word_t       data_o
);

    word_t       shifted;
    logic [7:0]  lo_byte;
    logic [15:0] lo_half;

    // Move the addressed byte down to lane zero
    assign shifted = rdata_i >> {addr_lo_i, 3'b000};

    assign lo_byte = shifted[7:0];
    assign lo_half = shifted[15:0];

    always_comb begin
        case (funct3_i)
            LD_B: begin
                data_o = {{24{lo_byte[7]}}, lo_byte};
            end
            LD_BU: begin
                data_o = {24'b0, lo_byte};
            end
            LD_H: begin
                data_o = {{16{lo_half[15]}}, lo_half};
            end
            LD_HU: begin
                data_o = {16'b0, lo_half};
            end
            LD_W: begin
                data_o = shifted;
            end
            // Reserved funct3, pass the word through
            default: begin
                data_o = shifted;
            end
        endcase
    end

endmodule

/* design/reg_file.sv */
module reg_file
    import rv_isa_pkg::*;
#(
    parameter int NREGS = 32,
    localparam int AW = $clog2(NREGS)
) (
    input  logic          clk,
    input  logic          arst_n_i,
    input  logic          we_i,
    input  logic [AW-1:0] waddr_i,
    input  word_t         wdata_i,
    input  logic [AW-1:0] raddr_a_i,
    input  logic [AW-1:0] raddr_b_i,
    output word_t         rdata_a_o,
    output word_t         rdata_b_o
);

    word_t regs [NREGS];

    // x0 is never written, so it keeps its reset value
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Combinational read ports
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

    // Storage behind x0 must hold zero across every write
    a_x0_zero: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        regs[0] == '0
    ) else $error("reg_file: x0 storage is nonzero");

endmodule

/* design/wb_stage.sv */
module wb_stage
    import rv_isa_pkg::*;
    import wb_cfg_pkg::*;
#(
    parameter int NREGS = 32,
    localparam int AW = $clog2(NREGS)
) (
    input  logic          clk,
    input  logic          arst_n_i,
    // Beat from the memory stage
    input  logic          valid_i,
    input  word_t         pc_i,
    input  word_t         inst_i,
    input  word_t         result_i,
    input  word_t         rdata_i,
    // Load aligner interface
    output load_width_e   load_funct3_o,
    output byte_off_t     load_addr_lo_o,
    output word_t         load_rdata_o,
    input  word_t         load_data_i,
    // Register file write port
    output logic          rf_we_o,
    output logic [AW-1:0] rf_waddr_o,
    output word_t         rf_wdata_o,
    // Retire report
    output logic          retire_o,
    output word_t         retire_pc_o
);

    logic       valid_q;
    word_t      pc_q;
    word_t      inst_q;
    word_t      result_q;
    word_t      rdata_q;
    opcode_e    opcode;
    logic [4:0] rd;
    wb_sel_e    wb_sel;
    logic       op_known;
    logic       misaligned;

    // Stage register, loaded every cycle since writeback never stalls
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q  <= 1'b0;
            pc_q     <= RESET_PC;
            inst_q   <= '0;
            result_q <= '0;
            rdata_q  <= '0;
        end else begin
            valid_q  <= valid_i;
            pc_q     <= pc_i;
            inst_q   <= inst_i;
            result_q <= result_i;
            rdata_q  <= rdata_i;
        end
    end

    assign opcode = opcode_e'(inst_q[OPCODE_MSB:OPCODE_LSB]);
    assign rd     = inst_q[RD_MSB:RD_LSB];

    // Writeback source per opcode
    always_comb begin
        wb_sel   = WB_NONE;
        op_known = 1'b1;
        case (opcode)
            OP_LUI, OP_AUIPC, OP_IMM, OP_REG: wb_sel = WB_ALU;
            OP_JAL, OP_JALR:                  wb_sel = WB_LINK;
            OP_LOAD:                          wb_sel = WB_LOAD;
            // CSR accesses retire without a write
            OP_STORE, OP_BRANCH, OP_SYSTEM:   wb_sel = WB_NONE;
            default:                          op_known = 1'b0;
        endcase
    end

    always_comb begin
        case (wb_sel)
            WB_LINK: rf_wdata_o = pc_q + PC_STEP;
            WB_ALU:  rf_wdata_o = result_q;
            WB_LOAD: rf_wdata_o = load_data_i;
            default: rf_wdata_o = '0;
        endcase
    end

    assign rf_we_o    = valid_q && (wb_sel != WB_NONE);
    // Upper rd bits are dropped for RV32E
    assign rf_waddr_o = rd[AW-1:0];

    // The ALU result doubles as the load address
    assign load_funct3_o  = load_width_e'(inst_q[FUNCT3_MSB:FUNCT3_LSB]);
    assign load_addr_lo_o = result_q[1:0];
    assign load_rdata_o   = rdata_q;

    assign retire_o    = valid_q;
    assign retire_pc_o = pc_q;

    assign misaligned = ((load_funct3_o == LD_H || load_funct3_o == LD_HU) && result_q[0])
                     || ((load_funct3_o == LD_W) && (result_q[1:0] != 2'b00));

    a_we_retire: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        rf_we_o |-> retire_o
    ) else $error("wb_stage: register write without retire");

    // Upstream must only hand over decodable instructions
    a_known_op: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        retire_o |-> op_known
    ) else $error("wb_stage: retiring unknown opcode %h", inst_q[OPCODE_MSB:OPCODE_LSB]);

    a_load_aligned: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (retire_o && opcode == OP_LOAD) |-> !misaligned
    ) else $error("wb_stage: misaligned load at %h", result_q);

endmodule

/* design/wb_top.sv */
module wb_top
    import rv_isa_pkg::*;
    import wb_cfg_pkg::*;
#(
    parameter int NREGS = 32,
    localparam int AW = $clog2(NREGS)
) (
    input  logic          clk,
    input  logic          arst_n_i,
    // Memory stage handover
    input  logic          mem_valid_i,
    input  word_t         mem_pc_i,
    input  word_t         mem_inst_i,
    input  word_t         mem_result_i,
    input  word_t         mem_rdata_i,
    // External read ports
    input  logic [AW-1:0] rs1_addr_i,
    input  logic [AW-1:0] rs2_addr_i,
    output word_t         rs1_data_o,
    output word_t         rs2_data_o,
    // Retire report
    output logic          retire_o,
    output word_t         retire_pc_o
);

    load_width_e   load_funct3;
    byte_off_t     load_addr_lo;
    word_t         load_rdata;
    word_t         load_data;
    logic          rf_we;
    logic [AW-1:0] rf_waddr;
    word_t         rf_wdata;

    wb_stage #(
        .NREGS(NREGS)
    ) u_wb_stage (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .valid_i       (mem_valid_i),
        .pc_i          (mem_pc_i),
        .inst_i        (mem_inst_i),
        .result_i      (mem_result_i),
        .rdata_i       (mem_rdata_i),
        .load_funct3_o (load_funct3),
        .load_addr_lo_o(load_addr_lo),
        .load_rdata_o  (load_rdata),
        .load_data_i   (load_data),
        .rf_we_o       (rf_we),
        .rf_waddr_o    (rf_waddr),
        .rf_wdata_o    (rf_wdata),
        .retire_o      (retire_o),
        .retire_pc_o   (retire_pc_o)
    );

    load_align u_load_align (
        .funct3_i (load_funct3),
        .addr_lo_i(load_addr_lo),
        .rdata_i  (load_rdata),
        .data_o   (load_data)
    );

    reg_file #(
        .NREGS(NREGS)
    ) u_reg_file (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .raddr_a_i(rs1_addr_i),
        .raddr_b_i(rs2_addr_i),
        .rdata_a_o(rs1_data_o),
        .rdata_b_o(rs2_data_o)
    );

endmodule

/* tb/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Reset held over the first two rising edges
    initial begin
        arst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule

/* tb/wb_top_tb.sv */
module wb_top_tb
    import rv_isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NREGS     = 32;
    localparam int AW        = $clog2(NREGS);
    localparam int COLS      = 7;
    localparam int MAX_CASES = 64;
    localparam int TIMEOUT   = 20;

    // Column order of one case line
    localparam int C_PC    = 0;
    localparam int C_INST  = 1;
    localparam int C_RES   = 2;
    localparam int C_RDATA = 3;
    localparam int C_RET   = 4;
    localparam int C_REG   = 5;
    localparam int C_EXP   = 6;

    logic          clk;
    logic          arst_n;
    logic          mem_valid;
    word_t         mem_pc;
    word_t         mem_inst;
    word_t         mem_result;
    word_t         mem_rdata;
    logic [AW-1:0] rs1_addr;
    logic [AW-1:0] rs2_addr;
    word_t         rs1_data;
    word_t         rs2_data;
    logic          retire;
    word_t         retire_pc;

    word_t case_mem [MAX_CASES*COLS];
    int    drive_cyc [MAX_CASES];
    int    n_cases;
    int    n_valid;
    int    n_driven;
    int    n_retired;
    int    cyc;
    int    value_errs;
    int    other_errs;
    logic  stop;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .arst_n_o(arst_n)
    );

    wb_top #(
        .NREGS(NREGS)
    ) dut (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .mem_valid_i (mem_valid),
        .mem_pc_i    (mem_pc),
        .mem_inst_i  (mem_inst),
        .mem_result_i(mem_result),
        .mem_rdata_i (mem_rdata),
        .rs1_addr_i  (rs1_addr),
        .rs2_addr_i  (rs2_addr),
        .rs1_data_o  (rs1_data),
        .rs2_data_o  (rs2_data),
        .retire_o    (retire),
        .retire_pc_o (retire_pc)
    );

    // A beat driven at count c retires while the count reads c+2
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    always @(negedge clk or negedge arst_n) begin
        if (!arst_n) begin
            n_retired <= 0;
        end else if (retire) begin
            n_retired <= n_retired + 1;
        end
    end

    task automatic check_word(input string name, input string tag, input word_t actual,
                              input word_t expected);
        if (actual !== expected) begin
            value_errs++;
            $display("Error: %s = %h, expected %h (%s)", name, actual, expected, tag);
        end
    endtask

    task automatic check_bit(input string name, input string tag, input logic actual,
                             input logic expected);
        if (actual !== expected) begin
            value_errs++;
            $display("Error: %s = %h, expected %h (%s)", name, actual, expected, tag);
        end
    endtask

    task automatic flag_failure(input string what);
        other_errs++;
        $display("%s", what);
    endtask

    task automatic load_cases();
        $readmemh("tb/wb_cases.txt", case_mem);
        // All ones in the pc column ends the list
        while (n_cases < MAX_CASES && case_mem[n_cases*COLS+C_PC] != 32'hffff_ffff) begin
            if (case_mem[n_cases*COLS+C_RET][0]) begin
                n_valid++;
            end
            n_cases++;
        end
        if (n_cases == 0) begin
            flag_failure("No cases were read from tb/wb_cases.txt");
            stop = 1'b1;
        end
    endtask

    task automatic check_reset_state();
        for (int r = 0; r < NREGS; r++) begin
            @(posedge clk);
            rs1_addr <= r[AW-1:0];
            rs2_addr <= AW'(NREGS - 1 - r);
            @(negedge clk);
            check_bit("retire_o", "after reset", retire, 1'b0);
            check_word("rs1_data_o", $sformatf("reset x%0d", r), rs1_data, '0);
            check_word("rs2_data_o", $sformatf("reset x%0d", NREGS - 1 - r), rs2_data, '0);
        end
    endtask

    task automatic drive_cases();
        int gap;
        for (int i = 0; i < n_cases && !stop; i++) begin
            gap = $urandom_range(2, 0);
            // Idle cycles carry junk that must not retire
            for (int g = 0; g < gap; g++) begin
                @(posedge clk);
                mem_valid  <= 1'b0;
                mem_inst   <= $urandom;
                mem_result <= $urandom;
            end
            @(posedge clk);
            mem_valid    <= case_mem[i*COLS+C_RET][0];
            mem_pc       <= case_mem[i*COLS+C_PC];
            mem_inst     <= case_mem[i*COLS+C_INST];
            mem_result   <= case_mem[i*COLS+C_RES];
            mem_rdata    <= case_mem[i*COLS+C_RDATA];
            drive_cyc[i] = cyc;
            n_driven     = i + 1;
        end
        @(posedge clk);
        mem_valid <= 1'b0;
    endtask

    task automatic check_cases();
        int            t;
        int            base;
        string         tag;
        logic [AW-1:0] rd;
        for (int i = 0; i < n_cases && !stop; i++) begin
            base = i * COLS;
            tag  = $sformatf("case %0d", i);
            rd   = case_mem[base+C_REG][AW-1:0];
            t    = 0;
            while (n_driven <= i && t < TIMEOUT) begin
                @(negedge clk);
                t++;
            end
            if (n_driven <= i) begin
                flag_failure($sformatf("Case %0d was never driven", i));
                stop = 1'b1;
                break;
            end
            t = 0;
            if (case_mem[base+C_RET][0]) begin
                while (!retire && t < TIMEOUT) begin
                    @(negedge clk);
                    t++;
                end
                if (!retire) begin
                    flag_failure($sformatf("Timed out waiting for case %0d to retire", i));
                    stop = 1'b1;
                    break;
                end
                if (cyc != drive_cyc[i] + 2) begin
                    flag_failure($sformatf("Case %0d retired at the wrong cycle", i));
                end
                check_word("retire_pc_o", tag, retire_pc, case_mem[base+C_PC]);
            end else begin
                // Slot where this beat would retire if it were valid
                while (cyc < drive_cyc[i] + 2 && t < TIMEOUT) begin
                    @(negedge clk);
                    t++;
                end
                if (cyc < drive_cyc[i] + 2) begin
                    flag_failure($sformatf("Timed out waiting for the slot of case %0d", i));
                    stop = 1'b1;
                    break;
                end
                check_bit("retire_o", tag, retire, 1'b0);
            end
            // Write lands on the next edge and shows on both read ports
            @(posedge clk);
            rs1_addr <= rd;
            rs2_addr <= rd;
            @(negedge clk);
            check_word("rs1_data_o", tag, rs1_data, case_mem[base+C_EXP]);
            check_word("rs2_data_o", tag, rs2_data, case_mem[base+C_EXP]);
        end
    endtask

    initial begin
        int t;
        mem_valid  <= 1'b0;
        mem_pc     <= '0;
        mem_inst   <= '0;
        mem_result <= '0;
        mem_rdata  <= '0;
        rs1_addr   <= '0;
        rs2_addr   <= '0;
        value_errs = 0;
        other_errs = 0;
        n_cases    = 0;
        n_valid    = 0;
        n_driven   = 0;
        stop       = 1'b0;
        t          = 0;
        void'($urandom(2));
        load_cases();
        while (arst_n !== 1'b1 && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        if (arst_n !== 1'b1) begin
            flag_failure("Reset was never released");
            stop = 1'b1;
        end
        if (!stop) begin
            check_reset_state();
            fork
                drive_cases();
                check_cases();
            join
            @(posedge clk);
            if (!stop && n_retired != n_valid) begin
                flag_failure($sformatf("Saw %0d retire pulses for %0d valid beats",
                                       n_retired, n_valid));
            end
        end
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* tb/wb_cases.txt */
// Columns: pc inst result rdata retire reg expected
// retire 0 drives the beat with valid low, reg is read back afterwards on both ports
// ALU writes
00001000 003100b3 12345678 deadbeef 1 01 12345678
00001004 fff00113 ffffffff deadbeef 1 02 ffffffff
00001008 abcde1b7 abcde000 00000000 1 03 abcde000
0000100c 00001217 0000200c 00000000 1 04 0000200c
// Links
00001010 010002ef 00001020 00000000 1 05 00001014
00001020 00008367 12345678 00000000 1 06 00001024
// Loads, read word 8a7b6c5d unless noted
00001024 00010383 00000100 8a7b6c5d 1 07 0000005d
00001028 00010403 00000101 8a7b6c5d 1 08 0000006c
0000102c 00010483 00000102 8a7b6c5d 1 09 0000007b
00001030 00010503 00000103 8a7b6c5d 1 0a ffffff8a
00001034 00014583 00000103 8a7b6c5d 1 0b 0000008a
00001038 00014603 00000104 000000f1 1 0c 000000f1
0000103c 00014683 00000106 8a7b6c5d 1 0d 0000007b
00001040 00011703 00000108 8a7b6c5d 1 0e 00006c5d
00001044 00011783 0000010a 8a7b6c5d 1 0f ffff8a7b
00001048 00015803 0000010c 1234f00d 1 10 0000f00d
0000104c 00015883 0000010e 8a7b6c5d 1 11 00008a7b
00001050 00012903 00000110 8a7b6c5d 1 12 8a7b6c5d
00001054 00011983 00000114 1234f00d 1 13 fffff00d
// Store, branch and system retire without a write
00001058 00112223 00000104 deadbeef 1 04 0000200c
0000105c 00208463 55555555 deadbeef 1 08 0000006c
00001060 300092f3 cafef00d 00000000 1 05 00001014
00001064 00000073 00000000 00000000 1 00 00000000
// rd is x0
00001068 00500013 00000005 00000000 1 00 00000000
0000106c 00012003 00000110 8a7b6c5d 1 00 00000000
00001070 0040006f 00001074 00000000 1 00 00000000
// Beats without valid leave the registers alone
00001074 003100b3 ffffffff 00000000 0 01 12345678
00001078 111111b7 11111000 00000000 0 03 abcde000
0000107c 003100b3 0f0f0f0f 00000000 1 01 0f0f0f0f
00001080 fff00113 00000000 00000000 0 02 ffffffff
// End marker
ffffffff 00000000 00000000 00000000 0 00 00000000

/* flist.f */
design/rv_isa_pkg.sv
design/wb_cfg_pkg.sv
design/load_align.sv
design/reg_file.sv
design/wb_stage.sv
design/wb_top.sv
tb/tb_clock_gen.sv
tb/wb_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the writeback testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=wb_top_tb_sim
LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        -f flist.f --top-module wb_top_tb \
        --Mdir "$BUILD_DIR" -o "$SIM_BIN"; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
    echo "Run passed"
    exit 0
else
    echo "Run failed, see $LOG"
    exit 1
fi
